//--- sources.f
source/deser_pkg.sv
source/lane_if.sv
source/deser_lane.sv
source/word_align.sv
source/frame_packer.sv
source/word_fifo.sv
source/deser_top.sv
verif/deser_props.sv
verif/deser_tb.sv

//--- verif/deser_tb.sv
// deser_tb
// directed testbench for the multi-lane serial receiver that sends
// word slots as lsb-first serial bits per lane and checks lock,
// frame order, idle filtering, back-pressure, overflow and reset

`timescale 1ns/1ps

module deser_tb;

	logic                              clk;
	logic                              rst_n;
	logic [deser_pkg::CHANNEL_NUM-1:0] din;
	logic                              out_valid;
	logic                              out_ready;
	deser_pkg::frame_t                 out_data;
	logic                              aligned;
	logic                              overflow;

	deser_pkg::frame_t     tx_q [$];  // word slots still to be sent
	deser_pkg::frame_t     exp_q [$]; // frames expected, in order
	deser_pkg::frame_t     rx_q [$];  // frames taken off the output
	bit                    lane_q [deser_pkg::CHANNEL_NUM][$]; // serial bits per lane
	deser_pkg::lane_word_t prev_word [deser_pkg::CHANNEL_NUM];
	logic [deser_pkg::CHANNEL_NUM-1:0] lane_delay; // lane runs one slot late
	int                    word_phase = 0;
	logic [15:0]           lfsr_state = 16'd19;
	string                 cur_test;
	int                    test_errors = 0;
	int                    error_count = 0;
	int                    tests_run = 0;
	int                    tests_failed = 0;

	deser_top u_deser_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.din       (din),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data),
		.aligned   (aligned),
		.overflow  (overflow)
	);

	always #20 clk = ~clk; // 40 ns period

	//------------------------------
	// serial driver and monitor
	//------------------------------
	// one frame slot every DESER_WIDTH clocks goes out as lane bits
	always @(posedge clk) begin : drive_bits
		deser_pkg::frame_t     slot;
		deser_pkg::lane_word_t w;
		if (word_phase == 0) begin
			if (tx_q.size() != 0)
				slot = tx_q.pop_front();
			else
				slot = {deser_pkg::CHANNEL_NUM{deser_pkg::TRAIN_PATTERN}}; // idle
			for (int c = 0; c < deser_pkg::CHANNEL_NUM; c++) begin
				w = slot[c*deser_pkg::DESER_WIDTH +: deser_pkg::DESER_WIDTH];
				if (lane_delay[c])
					w = prev_word[c]; // delayed lane sends the older word
				prev_word[c] = slot[c*deser_pkg::DESER_WIDTH +: deser_pkg::DESER_WIDTH];
				for (int b = 0; b < deser_pkg::DESER_WIDTH; b++)
					lane_q[c].push_back(w[b]); // lsb first on the wire
			end
		end
		word_phase = (word_phase + 1) % deser_pkg::DESER_WIDTH;
		for (int c = 0; c < deser_pkg::CHANNEL_NUM; c++)
			din[c] <= lane_q[c].pop_front();
	end

	always @(posedge clk) begin
		if (rst_n && out_valid && out_ready)
			rx_q.push_back(out_data); // transfer on this edge
	end

	//------------------------------
	// random data and bookkeeping
	//------------------------------
	function automatic logic next_rand_bit();
		logic lsb;
		lsb        = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb)
			lfsr_state = lfsr_state ^ 16'hB400; // galois taps 16,14,13,11
		return lsb;
	endfunction

	function automatic deser_pkg::lane_word_t random_word();
		deser_pkg::lane_word_t w;
		do begin
			for (int b = 0; b < deser_pkg::DESER_WIDTH; b++)
				w[b] = next_rand_bit();
		end while (w == deser_pkg::TRAIN_PATTERN); // keep data off the pattern
		return w;
	endfunction

	task automatic queue_random(input int n);
		deser_pkg::frame_t f;
		for (int i = 0; i < n; i++) begin
			for (int c = 0; c < deser_pkg::CHANNEL_NUM; c++)
				f[c*deser_pkg::DESER_WIDTH +: deser_pkg::DESER_WIDTH] = random_word();
			tx_q.push_back(f);
			exp_q.push_back(f); // channel 0 in the low byte
		end
	endtask

	task automatic start_test(input string name);
		cur_test    = name;
		test_errors = 0;
		tests_run++;
		rx_q.delete();
		exp_q.delete();
	endtask

	task automatic finish_test();
		if (test_errors == 0) begin
			$display("test %s: passed", cur_test);
		end else begin
			$display("test %s: failed with %0d error(s)", cur_test, test_errors);
			tests_failed++;
		end
	endtask

	function automatic void note_error();
		test_errors++;
		error_count++;
	endfunction

	task automatic require(input bit cond, input string what);
		assert (cond) else begin
			$display("ERROR %s: %s", cur_test, what);
			note_error();
		end
	endtask

	task automatic compare_received(input int n);
		for (int i = 0; i < n && i < rx_q.size(); i++) begin
			assert (rx_q[i] === exp_q[i]) else begin
				$display("FAIL %s frame %0d: expected %h actual %h",
					cur_test, i, exp_q[i], rx_q[i]);
				note_error();
			end
		end
	endtask

	//------------------------------
	// waits, each with a timeout
	//------------------------------
	task automatic await_lock();
		int cycles;
		cycles = 0;
		while (!aligned && cycles < 4000) begin
			@(negedge clk);
			cycles++;
			require(aligned || !out_valid, "out_valid raised before the lanes locked");
		end
		require(aligned, "lanes did not lock before the timeout");
	endtask

	task automatic collect_frames(input int n);
		int cycles;
		cycles = 0;
		while (rx_q.size() < n && cycles < 3000) begin
			@(negedge clk);
			cycles++;
		end
		require(rx_q.size() >= n, "timeout, too few frames at the output");
	endtask

	// empty the slot queue and let the last slot clear the lanes
	task automatic drain_driver();
		int cycles;
		cycles = 0;
		while (tx_q.size() != 0 && cycles < 3000) begin
			@(negedge clk);
			cycles++;
		end
		require(tx_q.size() == 0, "serial driver did not drain its slot queue");
		repeat (8 * deser_pkg::DESER_WIDTH) @(negedge clk);
	endtask

	// marker slot shows which lanes the packer groups a word early
	task automatic calibrate_lanes();
		deser_pkg::frame_t     marker;
		deser_pkg::frame_t     got;
		deser_pkg::lane_word_t mark;
		bit                    found;
		for (int c = 0; c < deser_pkg::CHANNEL_NUM; c++)
			marker[c*deser_pkg::DESER_WIDTH +: deser_pkg::DESER_WIDTH] = 8'hA0 + 8'(c);
		@(posedge clk);
		out_ready <= 1'b1;
		rx_q.delete();
		tx_q.push_back(marker);
		drain_driver();
		require(rx_q.size() == 1 || rx_q.size() == 2, "marker slot not packed into 1 or 2 frames");
		for (int c = 0; c < deser_pkg::CHANNEL_NUM; c++) begin
			mark  = marker[c*deser_pkg::DESER_WIDTH +: deser_pkg::DESER_WIDTH];
			found = 1'b0;
			for (int f = 0; f < rx_q.size(); f++) begin
				got = rx_q[f];
				if (got[c*deser_pkg::DESER_WIDTH +: deser_pkg::DESER_WIDTH] == mark) begin
					found = 1'b1;
					if (f == 0 && rx_q.size() == 2)
						lane_delay[c] = 1'b1; // packed one word ahead
				end
			end
			require(found, "lane marker missing from the output");
		end
		rx_q.delete();
	endtask

	//------------------------------
	// directed tests
	//------------------------------
	task automatic lock_lanes();
		start_test("alignment");
		await_lock();
		calibrate_lanes();
		finish_test();
	endtask

	task automatic stream_frames();
		start_test("data_order");
		@(posedge clk);
		out_ready <= 1'b1;
		queue_random(20);
		collect_frames(20);
		drain_driver();
		require(rx_q.size() == 20, "frame count differs from the 20 sent");
		compare_received(20);
		finish_test();
	endtask

	task automatic filter_idle();
		start_test("idle_filter");
		@(posedge clk);
		out_ready <= 1'b1;
		repeat (16)
			tx_q.push_back({deser_pkg::CHANNEL_NUM{deser_pkg::TRAIN_PATTERN}});
		drain_driver();
		require(rx_q.size() == 0, "frame delivered for training-only input");
		finish_test();
	endtask

	task automatic hold_under_stall();
		start_test("backpressure");
		@(posedge clk);
		out_ready <= 1'b0;
		queue_random(deser_pkg::FIFO_DEPTH);
		drain_driver();
		require(out_valid, "no frame offered while the output was stalled");
		@(posedge clk);
		out_ready <= 1'b1;
		collect_frames(deser_pkg::FIFO_DEPTH);
		compare_received(deser_pkg::FIFO_DEPTH);
		require(!overflow, "overflow set although the FIFO never overran");
		finish_test();
	endtask

	task automatic lose_on_overflow();
		start_test("overflow");
		@(posedge clk);
		out_ready <= 1'b0;
		queue_random(deser_pkg::FIFO_DEPTH + 3);
		drain_driver();
		require(overflow, "overflow not set after overrunning the FIFO");
		@(posedge clk);
		out_ready <= 1'b1;
		collect_frames(deser_pkg::FIFO_DEPTH);
		drain_driver();
		require(rx_q.size() == deser_pkg::FIFO_DEPTH, "dropped frames reached the output");
		compare_received(deser_pkg::FIFO_DEPTH);
		require(overflow, "overflow cleared without a reset");
		finish_test();
	endtask

	task automatic recover_from_reset();
		start_test("reset");
		@(posedge clk);
		out_ready <= 1'b1;
		queue_random(6);
		repeat (3 * deser_pkg::DESER_WIDTH) @(negedge clk); // data in flight
		@(posedge clk);
		rst_n <= 1'b0;
		@(negedge clk);
		require(!aligned, "aligned still high during reset");
		require(!overflow, "overflow still high during reset");
		require(!out_valid, "out_valid still high during reset");
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		require(!aligned && !overflow && !out_valid, "flags high right after reset release");
		await_lock();
		finish_test();
	endtask

	//------------------------------
	// main sequence
	//------------------------------
	initial begin
		int offset;
		int prop_errors;
		clk        = 1'b0;
		rst_n      = 1'b0;
		din        = '0;
		out_ready  = 1'b0;
		lane_delay = '0;
		// each lane starts a random 0..7 bits into its first word
		for (int c = 0; c < deser_pkg::CHANNEL_NUM; c++) begin
			offset = 0;
			for (int b = 0; b < $clog2(deser_pkg::DESER_WIDTH); b++)
				offset = offset | (int'(next_rand_bit()) << b);
			prev_word[c] = deser_pkg::TRAIN_PATTERN;
			repeat (offset)
				lane_q[c].push_back(1'b0);
		end
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		lock_lanes();
		stream_frames();
		filter_idle();
		hold_under_stall();
		lose_on_overflow();
		recover_from_reset();

		prop_errors = u_deser_top.u_word_fifo.u_deser_props.fail_count;
		$display("summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
			tests_run, tests_failed, error_count, prop_errors);
		if (error_count == 0 && prop_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- verif/deser_props.sv
// deser_props
// handshake and flag checks at the output FIFO; push and
// push_data seen here come straight from the frame packer

`timescale 1ns/1ps

module deser_props (
	input logic              clk,
	input logic              rst_n,
	input logic              push,
	input deser_pkg::frame_t push_data,
	input logic              out_valid,
	input logic              out_ready,
	input deser_pkg::frame_t out_data,
	input logic              overflow
);

	int fail_count = 0; // failed property attempts

	// stalled head frame must not move or vanish
	hold_on_stall: assert property (
		@(posedge clk) disable iff (!rst_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data))
	) else begin
		$error("out_data changed while the output was stalled");
		fail_count++;
	end

	// sticky until reset
	overflow_sticky: assert property (
		@(posedge clk) disable iff (!rst_n)
		overflow |=> overflow
	) else begin
		$error("overflow fell without a reset");
		fail_count++;
	end

	// idle frames are filtered before the FIFO
	no_idle_push: assert property (
		@(posedge clk) disable iff (!rst_n)
		push |-> (push_data != {deser_pkg::CHANNEL_NUM{deser_pkg::TRAIN_PATTERN}})
	) else begin
		$error("training-only frame pushed into the FIFO");
		fail_count++;
	end

endmodule

// attach to every FIFO instance
bind word_fifo deser_props u_deser_props (
	.clk       (clk),
	.rst_n     (rst_n),
	.push      (push),
	.push_data (push_data),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_data  (out_data),
	.overflow  (overflow)
);

//--- source/deser_top.sv
// deser_top
// multi-lane serial receiver: per-lane deserializer and aligner,
// frame packer and output FIFO behind a valid/ready interface

`timescale 1ns/1ps

module deser_top (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [deser_pkg::CHANNEL_NUM-1:0] din,       // one serial bit per lane
	output logic                              out_valid,
	input  logic                              out_ready,
	output logic [deser_pkg::FRAME_WIDTH-1:0] out_data,
	output logic                              aligned,   // all lanes locked
	output logic                              overflow   // sticky frame loss
);

	lane_if            lane_bus [deser_pkg::CHANNEL_NUM] ();
	logic              push;
	deser_pkg::frame_t push_data;

	//------------------------------
	// per-lane front end
	//------------------------------
	genvar ch;
	generate
		for (ch = 0; ch < deser_pkg::CHANNEL_NUM; ch++) begin : g_lane
			deser_lane u_deser_lane (
				.clk   (clk),
				.rst_n (rst_n),
				.din   (din[ch]),
				.lane  (lane_bus[ch])
			);

			word_align u_word_align (
				.clk   (clk),
				.rst_n (rst_n),
				.lane  (lane_bus[ch])
			);
		end
	endgenerate

	frame_packer u_frame_packer (
		.clk       (clk),
		.rst_n     (rst_n),
		.lanes     (lane_bus),
		.push      (push),
		.push_data (push_data),
		.aligned   (aligned)
	);

	// serial stream cannot be stalled, so full only matters inside the FIFO
	word_fifo u_word_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (push),
		.push_data (push_data),
		.full      (),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data),
		.overflow  (overflow)
	);

endmodule

//--- source/word_fifo.sv
// word_fifo
// synchronous frame FIFO with a valid/ready read side; a push
// while full is dropped and latches a sticky overflow flag

`timescale 1ns/1ps

module word_fifo (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              push,
	input  deser_pkg::frame_t push_data,
	output logic              full,
	output logic              out_valid,
	input  logic              out_ready,
	output deser_pkg::frame_t out_data,
	output logic              overflow
);

	deser_pkg::frame_t             mem [deser_pkg::FIFO_DEPTH]; // storage
	logic [deser_pkg::FIFO_AW-1:0] wr_ptr;
	logic [deser_pkg::FIFO_AW-1:0] rd_ptr;
	logic [deser_pkg::FIFO_CW-1:0] count;   // occupancy
	logic                          wr_en;
	logic                          rd_en;

	assign full      = (count == deser_pkg::FIFO_FULL_CNT);
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr]; // head entry, stable until popped
	assign wr_en     = push && !full;
	assign rd_en     = out_valid && out_ready;

	//------------------------------
	// pointers, count, overflow
	//------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == deser_pkg::FIFO_LAST) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == deser_pkg::FIFO_LAST) ? '0 : rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // none, or both at once
			endcase
			if (push && full)
				overflow <= 1'b1; // frame lost, held until reset
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= push_data;
	end

endmodule

//--- source/frame_packer.sv
// frame_packer
// collects one aligned word per lane, places the words into a
// frame in channel order, drops frames that are pure training
// pattern and pushes the rest towards the output FIFO

`timescale 1ns/1ps

module frame_packer (
	input  logic               clk,
	input  logic               rst_n,
	lane_if.pack               lanes [deser_pkg::CHANNEL_NUM],
	output logic               push,
	output deser_pkg::frame_t  push_data,
	output logic               aligned
);

	deser_pkg::lane_word_t                 lane_word [deser_pkg::CHANNEL_NUM]; // held words
	deser_pkg::lane_word_t                 bus_word  [deser_pkg::CHANNEL_NUM]; // live words
	logic [deser_pkg::CHANNEL_NUM-1:0]     have_word;    // word held per lane
	logic [deser_pkg::CHANNEL_NUM-1:0]     lane_valid;
	logic [deser_pkg::CHANNEL_NUM-1:0]     lane_aligned;
	deser_pkg::frame_t                     frame;        // assembled frame
	logic                                  all_have;     // frame complete
	logic                                  all_train;    // idle frame

	//------------------------------
	// flatten the lane bundles
	//------------------------------
	genvar i;
	generate
		for (i = 0; i < deser_pkg::CHANNEL_NUM; i++) begin : g_tap
			assign lane_valid[i]   = lanes[i].word_valid;
			assign lane_aligned[i] = lanes[i].aligned;
			assign bus_word[i]     = lanes[i].word;
		end
	endgenerate

	assign aligned  = &lane_aligned; // nothing is packed before this
	assign all_have = &have_word;

	// channel placement and idle check
	always_comb begin
		frame     = '0;
		all_train = 1'b1;
		for (int c = 0; c < deser_pkg::CHANNEL_NUM; c++) begin
			if (deser_pkg::CHANNEL_LITTLE)
				frame[c*deser_pkg::DESER_WIDTH +: deser_pkg::DESER_WIDTH] = lane_word[c];
			else
				frame[(deser_pkg::CHANNEL_NUM-1-c)*deser_pkg::DESER_WIDTH +:
					deser_pkg::DESER_WIDTH] = lane_word[c]; // channel 0 on top
			if (lane_word[c] != deser_pkg::TRAIN_PATTERN)
				all_train = 1'b0;
		end
	end

	//------------------------------
	// have-word flags and push
	//------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			have_word <= '0;
			push      <= 1'b0;
		end else begin
			push <= all_have && !all_train; // idle frames never reach the FIFO
			for (int c = 0; c < deser_pkg::CHANNEL_NUM; c++) begin
				if (lane_valid[c] && aligned)
					have_word[c] <= 1'b1;  // early lane of next frame
				else if (all_have)
					have_word[c] <= 1'b0;  // frame consumed
			end
		end
	end

	// word and frame registers
	always_ff @(posedge clk) begin
		if (all_have)
			push_data <= frame;
		for (int c = 0; c < deser_pkg::CHANNEL_NUM; c++) begin
			if (lane_valid[c] && aligned)
				lane_word[c] <= bus_word[c];
		end
	end

endmodule

//--- source/word_align.sv
// word_align
// per-lane training aligner: checks each lane word against the
// training pattern, requests bit slips until the boundary fits,
// then declares lock after LOCK_COUNT matches in a row

`timescale 1ns/1ps

module word_align (
	input  logic  clk,
	input  logic  rst_n,
	lane_if.align lane
);

	typedef enum logic [1:0] {
		HUNT,    // waiting for first match
		SETTLE,  // skipping words after a slip
		COUNT,   // collecting consecutive matches
		LOCKED   // boundary fixed until reset
	} align_state_t;

	align_state_t                   state;
	logic [deser_pkg::SETTLE_W-1:0] settle_cnt; // words skipped so far
	logic [deser_pkg::MATCH_W-1:0]  match_cnt;  // matches in a row
	logic                           match;

	assign match = (lane.word == deser_pkg::TRAIN_PATTERN);

	//------------------------------
	// alignment FSM
	//------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= HUNT;
			settle_cnt   <= '0;
			match_cnt    <= '0;
			lane.bitslip <= 1'b0;
		end else begin
			lane.bitslip <= 1'b0; // default, pulse lasts one clk
			if (lane.word_valid) begin
				case (state)
					HUNT, COUNT: begin
						if (match) begin
							if (match_cnt == deser_pkg::MATCH_LAST)
								state <= LOCKED;
							else
								state <= COUNT;
							match_cnt <= match_cnt + 1'b1;
						end else begin
							// wrong boundary, slip and start over
							lane.bitslip <= 1'b1;
							match_cnt    <= '0;
							settle_cnt   <= '0;
							state        <= SETTLE;
						end
					end
					SETTLE: begin
						// words around the slip are not trusted
						if (settle_cnt == deser_pkg::SETTLE_LAST)
							state <= HUNT;
						else
							settle_cnt <= settle_cnt + 1'b1;
					end
					LOCKED: state <= LOCKED; // sticky
					default: state <= HUNT;
				endcase
			end
		end
	end

	assign lane.aligned = (state == LOCKED);

endmodule

//--- source/deser_lane.sv
// deser_lane
// shifts one serial lane, one bit per clk, into DESER_WIDTH-bit
// words; a bitslip stretches the current word period by one clk

`timescale 1ns/1ps

module deser_lane (
	input  logic clk,
	input  logic rst_n,
	input  logic din,
	lane_if.lane lane
);

	logic [deser_pkg::LANE_CNT_W-1:0] bit_cnt;    // position inside word
	deser_pkg::lane_word_t            shift_reg;  // running bit history
	deser_pkg::lane_word_t            shift_next; // history incl. din
	logic                             wrap;       // word boundary this clk

	//------------------------------
	// bit shifter
	//------------------------------
	// lsb first means the new bit enters at the top and walks down
	// so after a full word the oldest bit sits in bit 0
	always_comb begin
		if (deser_pkg::FIRST_BIT_LSB)
			shift_next = {din, shift_reg[deser_pkg::DESER_WIDTH-1:1]};
		else
			shift_next = {shift_reg[deser_pkg::DESER_WIDTH-2:0], din}; // msb-first
	end

	// boundary is held off while a slip is pending
	assign wrap = (bit_cnt == deser_pkg::LANE_LAST) && !lane.bitslip;

	//------------------------------
	// word counter
	//------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt         <= '0;
			lane.word_valid <= 1'b0;
		end else begin
			lane.word_valid <= wrap; // one-cycle strobe
			if (wrap)
				bit_cnt <= '0;
			else if (!lane.bitslip)
				bit_cnt <= bit_cnt + 1'b1;
			// a slip holds the counter one clk so the period becomes width+1
		end
	end

	// shift history and presented word
	always_ff @(posedge clk) begin
		shift_reg <= shift_next;
		if (wrap)
			lane.word <= shift_next; // present full word with the strobe
	end

endmodule

//--- source/lane_if.sv
// lane_if
// per-lane bundle between a serial lane deserializer, its
// word aligner and the frame packer

`timescale 1ns/1ps

interface lane_if;

	deser_pkg::lane_word_t word;   // last DESER_WIDTH bits of the lane
	logic                  word_valid; // one-cycle strobe per word
	logic                  bitslip;    // move boundary one bit later
	logic                  aligned;    // lane locked on training word

	// deserializer side
	modport lane (
		output word,
		output word_valid,
		input  bitslip
	);

	// aligner, owns the slip and lock flags
	modport align (
		input  word,
		input  word_valid,
		output bitslip,
		output aligned
	);

	// packer only listens
	modport pack (
		input  word,
		input  word_valid,
		input  aligned
	);

endinterface

//--- source/deser_pkg.sv
// deser_pkg
// shared sizes, training word and alignment constants for the
// multi-lane serial receiver, plus the lane word and frame types

package deser_pkg;

	//------------------------------
	// lane and frame geometry
	//------------------------------
	localparam int CHANNEL_NUM = 4;                         // serial lanes
	localparam int DESER_WIDTH = 8;                         // bits per lane word
	localparam int FRAME_WIDTH = CHANNEL_NUM * DESER_WIDTH; // one word per lane

	typedef logic [DESER_WIDTH-1:0] lane_word_t;
	typedef logic [FRAME_WIDTH-1:0] frame_t;

	// all eight rotations differ, so only one boundary matches
	localparam lane_word_t TRAIN_PATTERN = 8'h2F;

	localparam bit FIRST_BIT_LSB  = 1'b1; // first bit on wire -> bit 0
	localparam bit CHANNEL_LITTLE = 1'b1; // channel 0 in low byte

	//------------------------------
	// alignment and buffering
	//------------------------------
	localparam int LOCK_COUNT  = 4;  // matches in a row for lock
	localparam int SLIP_SETTLE = 2;  // words skipped after a slip
	localparam int FIFO_DEPTH  = 8;  // frames

	// derived counter widths and terminal values
	localparam int LANE_CNT_W = $clog2(DESER_WIDTH);
	localparam logic [LANE_CNT_W-1:0] LANE_LAST = LANE_CNT_W'(DESER_WIDTH - 1);

	localparam int SETTLE_W = $clog2(SLIP_SETTLE + 1);
	localparam logic [SETTLE_W-1:0] SETTLE_LAST = SETTLE_W'(SLIP_SETTLE - 1);

	localparam int MATCH_W = $clog2(LOCK_COUNT + 1);
	localparam logic [MATCH_W-1:0] MATCH_LAST = MATCH_W'(LOCK_COUNT - 1);

	localparam int FIFO_AW = $clog2(FIFO_DEPTH);             // pointer width
	localparam logic [FIFO_AW-1:0] FIFO_LAST = FIFO_AW'(FIFO_DEPTH - 1);
	localparam int FIFO_CW = $clog2(FIFO_DEPTH + 1);         // occupancy width
	localparam logic [FIFO_CW-1:0] FIFO_FULL_CNT = FIFO_CW'(FIFO_DEPTH);

endpackage
